/* src/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data path width
`define MIPS_XLEN 32

// First fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* src/isa_pkg.sv */
package isa_pkg;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,	// Function field selects the operation
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_xori  = 6'h0e,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a
	} funct_e;

	// Immediate is [15:0], jump index is [25:0]
	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} instr_t;

endpackage

/* src/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_mem_access, st_mem_writeback, st_halted
	} state_e;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui
	} alu_op_e;

	typedef enum logic {srca_pc, srca_reg} src_a_e;

	typedef enum logic [2:0] {
		srcb_reg, srcb_four, srcb_sext, srcb_zext, srcb_branch
	} src_b_e;

	typedef enum logic [1:0] {pc_alu, pc_alu_out, pc_jump, pc_reg} pc_src_e;

	typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} reg_dst_e;

	typedef enum logic [1:0] {wb_alu_out, wb_data, wb_pc} wb_src_e;

	typedef struct packed {
		logic     pc_write;
		logic     branch;
		logic     branch_ne;	// Take branch when operands differ
		logic     ir_write;
		logic     iord;	// Address from ALU result register
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
		src_a_e   src_a;
		src_b_e   src_b;
		pc_src_e  pc_src;
		reg_dst_e reg_dst;
		wb_src_e  wb_src;
		alu_op_e  alu_op;
	} ctrl_t;

endpackage

/* src/alu.sv */
`include "mips_cfg.svh"

module alu (
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  ctrl_pkg::alu_op_e     op,
	output logic [`MIPS_XLEN-1:0] y,
	output logic                  zero
);
	import ctrl_pkg::*;

	localparam int xlen = `MIPS_XLEN;

	logic less;

	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or:  y = a | b;
			alu_xor: y = a ^ b;
			alu_slt: y = {{(xlen-1){1'b0}}, less};	// Signed compare
			alu_lui: y = b << 16;
			default: y = '0;
		endcase
	end

	assign zero = (y == '0);	// Branch compare result

endmodule

/* src/reg_file.sv */
`include "mips_cfg.svh"

module reg_file (
	input  logic                  clk,
	input  logic [4:0]            ra1,
	input  logic [4:0]            ra2,
	input  logic [4:0]            wa,
	input  logic [`MIPS_XLEN-1:0] wd,
	input  logic                  we,
	output logic [`MIPS_XLEN-1:0] rd1,
	output logic [`MIPS_XLEN-1:0] rd2
);

	logic [`MIPS_XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (we && wa != 5'd0)	// $zero never changes
			regs[wa] <= wd;
	end

	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* src/main_decoder.sv */
module main_decoder (
	input  logic             clk,
	input  logic             reset,
	input  logic             waitrequest,
	input  isa_pkg::opcode_e op,
	input  isa_pkg::funct_e  funct,
	output ctrl_pkg::ctrl_t  ctrl,
	output logic             active
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	state_e state;
	state_e state_next;
	ctrl_t  word;
	logic   stall;

	always_comb begin
		word         = '0;
		word.src_a   = srca_pc;
		word.src_b   = srcb_four;
		word.pc_src  = pc_alu;
		word.reg_dst = dst_rt;
		word.wb_src  = wb_alu_out;
		word.alu_op  = alu_add;

		// Execute and memory access share the ALU setup so the result register holds
		if (state == st_execute || state == st_mem_access) begin
			word.src_a = srca_reg;
			case (op)
				op_rtype: begin
					word.src_b = srcb_reg;
					case (funct)
						fn_subu: word.alu_op = alu_sub;
						fn_and:  word.alu_op = alu_and;
						fn_or:   word.alu_op = alu_or;
						fn_xor:  word.alu_op = alu_xor;
						fn_slt:  word.alu_op = alu_slt;
						default: word.alu_op = alu_add;
					endcase
				end
				op_beq, op_bne: begin
					word.src_b  = srcb_reg;
					word.alu_op = alu_sub;	// Zero flag compares A and B
				end
				op_addiu, op_lw, op_sw: word.src_b = srcb_sext;
				op_slti: begin
					word.src_b  = srcb_sext;
					word.alu_op = alu_slt;
				end
				op_andi: begin
					word.src_b  = srcb_zext;
					word.alu_op = alu_and;
				end
				op_ori: begin
					word.src_b  = srcb_zext;
					word.alu_op = alu_or;
				end
				op_xori: begin
					word.src_b  = srcb_zext;
					word.alu_op = alu_xor;
				end
				op_lui: begin
					word.src_b  = srcb_zext;
					word.alu_op = alu_lui;
				end
				default: ;
			endcase
		end

		case (state)
			st_fetch: begin	// Read instruction and advance PC
				word.mem_read = 1'b1;
				word.ir_write = 1'b1;
				word.pc_write = 1'b1;
			end
			st_decode: word.src_b = srcb_branch;	// Branch target into result register
			st_execute: begin
				case (op)
					op_beq, op_bne: begin
						word.branch    = 1'b1;
						word.branch_ne = (op == op_bne);
						word.pc_src    = pc_alu_out;
					end
					op_j: begin
						word.pc_write = 1'b1;
						word.pc_src   = pc_jump;
					end
					op_rtype: begin
						word.pc_write = (funct == fn_jr);
						word.pc_src   = pc_reg;
					end
					default: ;
				endcase
			end
			st_mem_access: begin
				case (op)
					op_lw: begin
						word.mem_read = 1'b1;
						word.iord     = 1'b1;
					end
					op_sw: begin
						word.mem_write = 1'b1;
						word.iord      = 1'b1;
					end
					op_jal: begin	// Link gets PC + 4 while PC takes the target
						word.reg_write = 1'b1;
						word.reg_dst   = dst_ra;
						word.wb_src    = wb_pc;
						word.pc_write  = 1'b1;
						word.pc_src    = pc_jump;
					end
					op_rtype: begin
						word.reg_write = 1'b1;
						word.reg_dst   = dst_rd;
					end
					default: word.reg_write = 1'b1;	// Immediate ALU ops
				endcase
			end
			st_mem_writeback: begin
				word.reg_write = 1'b1;
				word.wb_src    = wb_data;
			end
			default: ;	// Halted drives nothing
		endcase
	end

	// Fetch and memory access hold while the bus waits
	assign stall = waitrequest && (state == st_fetch || state == st_mem_access);

	always_comb begin
		ctrl = word;
		if (stall) begin
			ctrl.pc_write  = 1'b0;
			ctrl.ir_write  = 1'b0;
			ctrl.reg_write = 1'b0;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_fetch:  if (!stall) state_next = st_decode;
			st_decode: state_next = st_execute;
			st_execute: begin
				case (op)
					op_beq, op_bne, op_j: state_next = st_fetch;
					op_jal, op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui, op_lw, op_sw:
						state_next = st_mem_access;
					op_rtype: begin
						case (funct)
							fn_jr: state_next = st_fetch;
							fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt:
								state_next = st_mem_access;
							default: state_next = st_halted;	// Unknown funct
						endcase
					end
					default: state_next = st_halted;	// Unknown opcode
				endcase
			end
			st_mem_access: begin
				if (!stall)
					state_next = (op == op_lw) ? st_mem_writeback : st_fetch;
			end
			st_mem_writeback: state_next = st_fetch;
			default: state_next = st_halted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_fetch;
		else
			state <= state_next;
	end

	assign active = (state != st_halted);

endmodule

/* src/datapath.sv */
`include "mips_cfg.svh"

module datapath (
	input  logic                  clk,
	input  logic                  reset,
	input  ctrl_pkg::ctrl_t       ctrl,
	output isa_pkg::instr_t       instr,
	output logic [`MIPS_XLEN-1:0] address,
	output logic [`MIPS_XLEN-1:0] writedata,
	output logic                  read,
	output logic                  write,
	input  logic [`MIPS_XLEN-1:0] readdata
);
	import ctrl_pkg::*;

	localparam int xlen = `MIPS_XLEN;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] data_reg;
	logic [xlen-1:0] reg_a;
	logic [xlen-1:0] reg_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] opnd_a;
	logic [xlen-1:0] opnd_b;
	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] wb_val;
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] jump_target;
	logic [15:0]     imm;
	logic [4:0]      wa;
	logic            alu_zero;
	logic            pc_load;

	assign imm         = instr[15:0];
	assign jump_target = {pc[xlen-1:28], instr[25:0], 2'b00};	// PC already advanced

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `MIPS_RESET_PC;
		else if (pc_load)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (ctrl.ir_write)
			instr <= readdata;
		if (ctrl.mem_read)
			data_reg <= readdata;	// Last capture is the completed read
		reg_a   <= rd1;
		reg_b   <= rd2;
		alu_out <= alu_y;
	end

	reg_file reg_file_inst (
		.clk (clk),
		.ra1 (instr.rs),
		.ra2 (instr.rt),
		.wa  (wa),
		.wd  (wb_val),
		.we  (ctrl.reg_write),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	always_comb begin
		opnd_a = (ctrl.src_a == srca_reg) ? reg_a : pc;
		case (ctrl.src_b)
			srcb_reg:    opnd_b = reg_b;
			srcb_sext:   opnd_b = {{(xlen-16){imm[15]}}, imm};
			srcb_zext:   opnd_b = {{(xlen-16){1'b0}}, imm};
			srcb_branch: opnd_b = {{(xlen-18){imm[15]}}, imm, 2'b00};
			default:     opnd_b = xlen'(4);
		endcase
	end

	alu alu_inst (
		.a    (opnd_a),
		.b    (opnd_b),
		.op   (ctrl.alu_op),
		.y    (alu_y),
		.zero (alu_zero)
	);

	always_comb begin
		case (ctrl.reg_dst)
			dst_rd:  wa = instr.rd;
			dst_ra:  wa = 5'd31;
			default: wa = instr.rt;
		endcase
		case (ctrl.wb_src)
			wb_data: wb_val = data_reg;
			wb_pc:   wb_val = pc;
			default: wb_val = alu_out;
		endcase
		case (ctrl.pc_src)
			pc_alu_out: pc_next = alu_out;
			pc_jump:    pc_next = jump_target;
			pc_reg:     pc_next = reg_a;
			default:    pc_next = alu_y;
		endcase
	end

	assign pc_load = ctrl.pc_write || (ctrl.branch && (alu_zero != ctrl.branch_ne));

	assign address   = ctrl.iord ? alu_out : pc;
	assign writedata = reg_b;
	assign read      = ctrl.mem_read;
	assign write     = ctrl.mem_write;

endmodule

/* src/mips_multicycle.sv */
`include "mips_cfg.svh"

module mips_multicycle (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  waitrequest,
	input  logic [`MIPS_XLEN-1:0] readdata,
	output logic [`MIPS_XLEN-1:0] address,
	output logic [`MIPS_XLEN-1:0] writedata,
	output logic                  read,
	output logic                  write,
	output logic                  active
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	ctrl_t  ctrl;
	instr_t instr;

	main_decoder main_decoder_inst (
		.clk         (clk),
		.reset       (reset),
		.waitrequest (waitrequest),
		.op          (instr.op),
		.funct       (instr.funct),
		.ctrl        (ctrl),
		.active      (active)
	);

	datapath datapath_inst (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.instr     (instr),
		.address   (address),
		.writedata (writedata),
		.read      (read),
		.write     (write),
		.readdata  (readdata)
	);

endmodule

/* test/mips_asserts.sv */
`include "mips_cfg.svh"

module mips_asserts (
	input logic                  clk,
	input logic                  reset,
	input logic                  waitrequest,
	input logic                  read,
	input logic                  write,
	input logic                  active,
	input logic [`MIPS_XLEN-1:0] address,
	input logic [`MIPS_XLEN-1:0] writedata
);

	int fail_count = 0;

	strobe_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			$error("read and write are high together");
			fail_count++;
		end

	// A stalled read keeps its request
	read_hold: assert property (@(posedge clk) disable iff (reset)
		read && waitrequest |=> read && !write && $stable(address))
		else begin
			$error("read request changed while waitrequest was high");
			fail_count++;
		end

	write_hold: assert property (@(posedge clk) disable iff (reset)
		write && waitrequest |=> write && $stable(address) && $stable(writedata))
		else begin
			$error("write request changed while waitrequest was high");
			fail_count++;
		end

	halted_idle: assert property (@(posedge clk) disable iff (reset)
		!active |-> !read && !write)
		else begin
			$error("bus strobe while the processor is halted");
			fail_count++;
		end

endmodule

bind mips_multicycle mips_asserts mips_asserts_inst (
	.clk         (clk),
	.reset       (reset),
	.waitrequest (waitrequest),
	.read        (read),
	.write       (write),
	.active      (active),
	.address     (address),
	.writedata   (writedata)
);

/* test/mips_multicycle_tb.sv */
`include "mips_cfg.svh"

module mips_multicycle_tb;
	import isa_pkg::*;

	localparam int clk_period = 8;
	localparam int n_random = 60;
	localparam int mem_words = 1024;
	localparam logic [31:0] data_base = 32'h0000_0800;
	localparam logic [31:0] dump_base = 32'h0000_0c00;

	logic                  clk;
	logic                  reset;
	logic                  waitrequest;
	logic [`MIPS_XLEN-1:0] readdata;
	logic [`MIPS_XLEN-1:0] address;
	logic [`MIPS_XLEN-1:0] writedata;
	logic                  read;
	logic                  write;
	logic                  active;

	logic [31:0] mem [mem_words];	// Bus side memory
	logic [31:0] model_mem [mem_words];
	logic [31:0] model_regs [32];
	logic [31:0] exp_addr [$];	// Expected writes in order
	logic [31:0] exp_data [$];
	logic [31:0] lfsr_state;
	int          model_steps;
	int          limit_cycles = 0;
	int          transfers;
	int          halt_transfers;
	int          writes_seen;
	int          wait_left;
	logic        busy;	// Wait count already drawn for this transfer

	mips_multicycle mips_multicycle_inst (
		.clk         (clk),
		.reset       (reset),
		.waitrequest (waitrequest),
		.readdata    (readdata),
		.address     (address),
		.writedata   (writedata),
		.read        (read),
		.write       (write),
		.active      (active)
	);

	always #(clk_period / 2) clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		int          k;
		v = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_r(funct_e fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(opcode_e op, logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic build_program();
		int          i;
		int          t;
		logic [3:0]  kind;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [15:0] mem_off;
		logic [7:0]  slot;
		logic [1:0]  sub;
		for (i = 0; i < mem_words; i++)
			mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
		i = 0;
		while (i < n_random) begin
			kind = 4'(rand_bits(4));
			rs = 5'(rand_bits(5));
			rt = 5'(rand_bits(5));
			rd = 5'(rand_bits(5));
			imm = 16'(rand_bits(16));
			slot = 8'(rand_bits(8));
			mem_off = data_base[15:0] + {6'd0, slot, 2'b00};	// Data region only
			case (kind)
				4'd0:  mem[i] = enc_r(fn_addu, rs, rt, rd);
				4'd1:  mem[i] = enc_r(fn_subu, rs, rt, rd);
				4'd2:  mem[i] = enc_r(fn_and, rs, rt, rd);
				4'd3:  mem[i] = enc_r(fn_or, rs, rt, rd);
				4'd4:  mem[i] = enc_r(fn_xor, rs, rt, rd);
				4'd5:  mem[i] = enc_r(fn_slt, rs, rt, rd);
				4'd6:  mem[i] = enc_i(op_addiu, rs, rt, imm);
				4'd7:  mem[i] = enc_i(op_slti, rs, rt, imm);
				4'd8:  mem[i] = enc_i(op_andi, rs, rt, imm);
				4'd9:  mem[i] = enc_i(op_ori, rs, rt, imm);
				4'd10: mem[i] = enc_i(op_xori, rs, rt, imm);
				4'd11: mem[i] = enc_i(op_lui, rs, rt, imm);
				4'd12: mem[i] = enc_i(op_lw, 5'd0, rt, mem_off);
				4'd13: mem[i] = enc_i(op_sw, 5'd0, rt, mem_off);
				4'd14: begin
					t = i + 1 + int'(rand_bits(3));	// Forward target only
					if (t > n_random)
						t = n_random;
					mem[i] = enc_i(imm[0] ? op_bne : op_beq, rs, rt, 16'(t - i - 1));
				end
				default: begin
					sub = 2'(rand_bits(2));
					if (sub[1] && i + 1 < n_random) begin
						// Load a forward address, then jump through it
						t = i + 2 + int'(rand_bits(3));
						if (t > n_random)
							t = n_random;
						if (rd == 5'd0)
							rd = 5'd1;
						mem[i] = enc_i(op_addiu, 5'd0, rd, 16'(t * 4));
						i++;
						mem[i] = enc_r(fn_jr, rd, 5'd0, 5'd0);
					end else begin
						t = i + 1 + int'(rand_bits(3));
						if (t > n_random)
							t = n_random;
						mem[i] = enc_j(sub[0] ? op_jal : op_j, 26'(t));
					end
				end
			endcase
			i++;
		end
		for (i = 0; i < 32; i++)	// Register dump
			mem[n_random + i] = enc_i(op_sw, 5'd0, 5'(i), dump_base[15:0] + 16'(i * 4));
		mem[n_random + 32] = {6'h3f, 26'd0};	// Undefined opcode ends the run
	endtask

	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] pc4;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] zext;
		logic [31:0] ea;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic        done;
		int          i;
		for (i = 0; i < mem_words; i++)
			model_mem[i] = mem[i];
		for (i = 0; i < 32; i++)
			model_regs[i] = '0;
		pc = `MIPS_RESET_PC;
		done = 1'b0;
		model_steps = 0;
		while (!done && model_steps < 1000) begin
			w = model_mem[pc[11:2]];
			pc4 = pc + 32'd4;
			rs = w[25:21];
			rt = w[20:16];
			rd = w[15:11];
			a = model_regs[rs];
			b = model_regs[rt];
			sext = {{16{w[15]}}, w[15:0]};
			zext = {16'd0, w[15:0]};
			ea = a + sext;
			model_steps++;
			pc = pc4;
			case (w[31:26])
				op_rtype: begin
					case (w[5:0])
						fn_addu: model_regs[rd] = a + b;
						fn_subu: model_regs[rd] = a - b;
						fn_and:  model_regs[rd] = a & b;
						fn_or:   model_regs[rd] = a | b;
						fn_xor:  model_regs[rd] = a ^ b;
						fn_slt:  model_regs[rd] = {31'd0, $signed(a) < $signed(b)};
						fn_jr:   pc = a;
						default: done = 1'b1;
					endcase
				end
				op_addiu: model_regs[rt] = a + sext;
				op_slti:  model_regs[rt] = {31'd0, $signed(a) < $signed(sext)};
				op_andi:  model_regs[rt] = a & zext;
				op_ori:   model_regs[rt] = a | zext;
				op_xori:  model_regs[rt] = a ^ zext;
				op_lui:   model_regs[rt] = {w[15:0], 16'd0};
				op_lw:    model_regs[rt] = model_mem[ea[11:2]];
				op_sw: begin
					model_mem[ea[11:2]] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				op_beq: if (a == b) pc = pc4 + (sext << 2);
				op_bne: if (a != b) pc = pc4 + (sext << 2);
				op_j:   pc = {pc4[31:28], w[25:0], 2'b00};
				op_jal: begin
					model_regs[31] = pc4;	// Link
					pc = {pc4[31:28], w[25:0], 2'b00};
				end
				default: done = 1'b1;
			endcase
			model_regs[0] = '0;
		end
	endtask

	task automatic log_write(input logic [31:0] addr, input logic [31:0] data);
		if (writes_seen >= exp_addr.size())
			fail_run("The processor wrote more words than the model expects");
		check_value("write address", exp_addr[writes_seen], addr);
		check_value("write data", exp_data[writes_seen], data);
		if (addr >= dump_base && addr < dump_base + 32'd128)
			check_value("register dump", model_regs[addr[6:2]], data);
		writes_seen++;
	endtask

	// Memory model samples at the edge and drives just after it
	always @(posedge clk) begin
		if (reset) begin
			busy = 1'b0;
		end else if ((read || write) && !waitrequest) begin
			if (transfers == 0) begin
				check_value("first transfer is a read", 32'd1, {31'd0, read});
				check_value("first fetch address", `MIPS_RESET_PC, address);
			end
			transfers++;
			busy = 1'b0;
			if (write) begin
				log_write(address, writedata);
				mem[address[11:2]] = writedata;
			end
		end
		#1;
		if (read || write) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'(rand_bits(2));	// 0 to 3 wait cycles
			end
			waitrequest = (wait_left != 0);
			if (wait_left != 0)
				wait_left--;
		end else begin
			waitrequest = 1'b0;
		end
		readdata = waitrequest ? rand_bits(32) : mem[address[11:2]];	// Junk while waiting
	end

	always @(posedge clk)
		if (mips_multicycle_inst.mips_asserts_inst.fail_count != 0)
			fail_run("A bus or control assertion failed");

	initial begin
		wait (limit_cycles != 0);
		#(limit_cycles * clk_period);
		fail_run($sformatf("Timeout: the processor did not halt within %0d cycles",
			limit_cycles));
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		waitrequest = 1'b0;
		readdata = '0;
		lfsr_state = 32'hf5c5_2537;
		busy = 1'b0;
		wait_left = 0;
		transfers = 0;
		writes_seen = 0;
		build_program();
		run_model();
		limit_cycles = 2 * (4 + (5 + 3) * model_steps);
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		wait (active == 1'b0);
		@(negedge clk);
		halt_transfers = transfers;
		repeat (10) @(posedge clk);
		@(negedge clk);
		check_value("transfers after halt", 32'(halt_transfers), 32'(transfers));
		check_value("write count", 32'(exp_addr.size()), 32'(writes_seen));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* mips_multicycle.f */
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/alu.sv
src/reg_file.sv
src/main_decoder.sv
src/datapath.sv
src/mips_multicycle.sv
test/mips_asserts.sv
test/mips_multicycle_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mips_multicycle_tb -f mips_multicycle.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vmips_multicycle_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^SIMULATION PASSED$'; then
	exit 0
fi
exit 1
